// ==== build.f ====
+incdir+source
source/rp_pkg.sv
source/adc_front.sv
source/dac_mix.sv
source/trig_route.sv
source/rp_analog_top.sv
dv/rp_analog_asserts.sv
dv/rp_analog_tb.sv

// ==== Bender.yml ====
package:
  name: rp_analog

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rp_pkg.sv
      - source/adc_front.sv
      - source/dac_mix.sv
      - source/trig_route.sv
      - source/rp_analog_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/rp_analog_asserts.sv
      - dv/rp_analog_tb.sv

// ==== dv/rp_analog_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the analog datapath top level
// inputs change on the falling edge and outputs are sampled on the
// rising edge before any register updates
// expected values come from a reference model fed with the current
// inputs and two cycles of input history
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

module rp_analog_tb import rp_pkg::*; ();

  localparam int N_ACQ   = 200;
  localparam int N_SAT   = 240;
  localparam int N_LOOP  = 200;
  localparam int N_GATE  = 200;
  localparam int N_MODE  = 64;
  localparam int N_RESET = 40;
  localparam int TOTAL_CYCLES  = 3 + N_ACQ + N_SAT + N_LOOP + N_GATE + N_MODE + N_RESET + 6;
  localparam int WATCHDOG_TIME = TOTAL_CYCLES * 10 + 500;

  localparam int T_ACQ = 0, T_SAT = 1, T_LOOP = 2, T_GATE = 3, T_MODE = 4, T_RESET = 5;
  localparam int SMP_MAX = (1 << (`RP_ADC_DW - 1)) - 1;  // 8191
  localparam int SMP_MIN = -(1 << (`RP_ADC_DW - 1));     // -8192

  // one snapshot of every DUT input
  typedef struct packed {
    logic                   rst;
    raw_pair_t              adc;
    smp_pair_t              gen;
    smp_pair_t              pid;
    logic                   loop;
    logic                   trig;
    logic                   trig_scope;
    logic                   trig_gen;
    daisy_mode_t            mode;
    logic [`RP_DAISY_W-1:0] rx;
    logic                   rdy;
    exp_bank_t              exp_n;
  } stim_t;

  typedef struct packed {
    acq_pair_t              acq;
    dac_pair_t              dac;
    logic                   dac_reset;
    logic                   trig_ext;
    logic [`RP_DAISY_W-1:0] tx;
    logic                   tx_dv;
    exp_bank_t              exp_n;
  } resp_t;

  logic                   adc_clk;
  logic                   rst_i;
  raw_pair_t              adc_i;
  smp_pair_t              gen_i, pid_i;
  logic                   loop_i, trig_i, trig_scope_i, trig_gen_i;
  daisy_mode_t            mode_i;
  logic [`RP_DAISY_W-1:0] daisy_rx_i;
  logic                   daisy_rdy_i;
  exp_bank_t              exp_n_i;
  acq_pair_t              acq_o;
  dac_pair_t              dac_o;
  logic                   dac_reset_o, trig_ext_o, daisy_tx_dv_o;
  logic [`RP_DAISY_W-1:0] daisy_tx_o;
  exp_bank_t              exp_n_o;

  logic [31:0] lfsr = 32'hdb4f8959;
  stim_t       hist1 = '0;  // inputs seen one edge ago
  stim_t       hist2 = '0;  // two edges ago
  string       test_name = "startup";
  int          n_edge = 0, n_tests = 0, n_checks = 0, n_errors = 0, test_errors = 0;

  rp_analog_top u_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  // saturation edge pairs as {gen, pid}
  function automatic logic [27:0] corner(input int i);
    case (i % 8)
      0:       return {14'sh1fff, 14'sh0000};  // exactly max
      1:       return {14'sh1fff, 14'sh0001};  // max + 1
      2:       return {14'sh2000, 14'sh0000};  // exactly min
      3:       return {14'sh2000, 14'sh3fff};  // min - 1
      4:       return {14'sh1fff, 14'sh1fff};  // full positive overflow
      5:       return {14'sh2000, 14'sh2000};  // full negative
      6:       return {14'sh1000, 14'sh0fff};  // 4096 + 4095
      default: return {14'sh3000, 14'sh2fff};  // -4096 - 4097
    endcase
  endfunction

  task automatic drive_cycle(input int kind, input int idx);
    logic [31:0] r;
    logic [27:0] c;
    @(negedge adc_clk);
    rst_i = (kind == T_RESET) && (idx < 3);
    r = rand_bits(28);
    adc_i = r[27:0];
    r = rand_bits(28);
    gen_i = r[27:0];
    r = rand_bits(28);
    pid_i = r[27:0];
    r = rand_bits(18);
    exp_n_i = r[17:0];
    r = rand_bits(7);
    {trig_i, trig_scope_i, trig_gen_i, daisy_rdy_i} = r[3:0];
    mode_i = r[6:4];
    loop_i = (kind == T_LOOP);
    r = rand_bits(2);
    daisy_rx_i = (r[1:0] == 2'b00) ? 16'h0010 : '0;  // mostly idle rx
    case (kind)
      T_SAT: begin
        if (idx % 2 == 0) begin
          c = corner(idx / 2);
          {gen_i.ch_a, pid_i.ch_a} = c;
          c = corner(idx / 2 + 3);
          {gen_i.ch_b, pid_i.ch_b} = c;
        end
      end
      T_GATE: begin
        r = rand_bits(5);
        daisy_rx_i = r[4] ? (16'h1 << r[3:0]) : '0;  // single bit must count
      end
      T_MODE: mode_i = idx[2:0];  // walk all eight combinations
      default: ;
    endcase
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    test_name   = name;
    test_errors = 0;
    for (int i = 0; i < n; i++) begin
      drive_cycle(kind, i);
    end
    @(negedge adc_clk);  // last inputs checked on the edge before
    n_tests++;
    $display("test %-12s %4d cycles  %0d errors", name, n, test_errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and checking
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`RP_ADC_DW-1:0] dac_code(input sample_t g, input sample_t p);
    int s;
    s = int'(g) + int'(p);
    if (s > SMP_MAX) s = SMP_MAX;
    else if (s < SMP_MIN) s = SMP_MIN;
    return ~s[`RP_ADC_DW-1:0];  // DAC takes the inverted code
  endfunction

  function automatic acq_t upper(input logic [`RP_ADC_DW-1:0] w);
    return acq_t'(w >> (`RP_ADC_DW - `RP_ADC_KEEP));
  endfunction

  // outputs expected on an edge from p1 and p2, the inputs of the two edges before
  function automatic resp_t ref_model(input stim_t cur, input stim_t p1, input stim_t p2);
    resp_t r;
    logic  rx_trig;
    logic  sel;
    if (p1.rst) r.acq = '0;
    else if (p1.loop) begin
      r.acq.ch_a = upper(dac_code(p1.gen.ch_a, p1.pid.ch_a));
      r.acq.ch_b = upper(dac_code(p1.gen.ch_b, p1.pid.ch_b));
    end else begin
      r.acq.ch_a = upper(p1.adc.ch_b);  // crossed
      r.acq.ch_b = upper(p1.adc.ch_a);
    end
    if (p1.rst || p2.rst) r.dac = '0;
    else begin
      r.dac.ch_a = dac_code(p2.gen.ch_b, p2.pid.ch_b);
      r.dac.ch_b = dac_code(p2.gen.ch_a, p2.pid.ch_a);
    end
    r.dac_reset = p1.rst;
    rx_trig     = !p1.rst && (p1.rx != '0);
    // external trigger blocked only by a daisy trigger in sync mode
    if (cur.mode.sync_en && rx_trig) r.trig_ext = 1'b0;
    else r.trig_ext = cur.trig;
    sel = cur.mode.trig_from_gen ? cur.trig_gen : cur.trig_scope;
    if (cur.mode.sync_en) begin
      r.tx    = sel ? '1 : '0;
      r.tx_dv = 1'b0;
    end else begin
      r.tx    = `RP_DAISY_IDLE;
      r.tx_dv = cur.rdy;
    end
    r.exp_n     = cur.exp_n;
    if (cur.mode.trig_pin_en) begin
      r.exp_n.dat[0] = cur.exp_n.dat[0] | sel;
      r.exp_n.dir[0] = 1'b1;
    end
    return r;
  endfunction

  task automatic check_val(input string field, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      test_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  initial begin : compare
    stim_t cur;
    resp_t exp_r;
    forever begin
      @(posedge adc_clk);
      cur   = {rst_i, adc_i, gen_i, pid_i, loop_i, trig_i, trig_scope_i, trig_gen_i,
               mode_i, daisy_rx_i, daisy_rdy_i, exp_n_i};
      exp_r = ref_model(cur, hist1, hist2);
      if (n_edge >= 1) begin  // registers undefined before the first edge
        check_val("acq_o", exp_r.acq, acq_o);
        check_val("dac_o", exp_r.dac, dac_o);
        check_val("dac_reset_o", exp_r.dac_reset, dac_reset_o);
        check_val("trig_ext_o", exp_r.trig_ext, trig_ext_o);
      end
      check_val("daisy_tx_o", exp_r.tx, daisy_tx_o);
      check_val("daisy_tx_dv_o", exp_r.tx_dv, daisy_tx_dv_o);
      check_val("exp_n_o", exp_r.exp_n, exp_n_o);
      hist2 = hist1;
      hist1 = cur;
      n_edge++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int n_assert;
    {rst_i, adc_i, gen_i, pid_i, loop_i, trig_i, trig_scope_i, trig_gen_i} = '0;
    {mode_i, daisy_rx_i, daisy_rdy_i, exp_n_i} = '0;
    rst_i = 1'b1;
    repeat (3) @(posedge adc_clk);  // three rising edges in reset
    @(negedge adc_clk);
    rst_i = 1'b0;
    run_test("acq_swap", T_ACQ, N_ACQ);
    run_test("dac_sat", T_SAT, N_SAT);
    run_test("loopback", T_LOOP, N_LOOP);
    run_test("daisy_gate", T_GATE, N_GATE);
    run_test("tx_and_exp", T_MODE, N_MODE);
    run_test("reset", T_RESET, N_RESET);
    n_assert = u_dut.u_asserts.fail_cnt;
    $display("summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
             n_tests, n_checks, n_errors, n_assert);
    if (n_errors == 0 && n_assert == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== dv/rp_analog_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// protocol checks bound into the analog top level
// all properties sample on the rising adc_clk edge
// fail_cnt counts every assertion failure
//////////////////////////////////////////////////////////////////////

module rp_analog_asserts import rp_pkg::*; (
  input logic        adc_clk,
  input logic        rst_i,
  input daisy_mode_t mode_i,
  input logic        dac_reset_o,
  input logic        daisy_tx_dv_o,
  input exp_bank_t   exp_n_o
);

  int fail_cnt = 0;

  // DAC reset pin one cycle behind reset
  a_dac_reset: assert property (@(posedge adc_clk) rst_i |=> dac_reset_o)
    else begin
      fail_cnt++;
      $error("dac_reset_o not high one cycle after rst_i");
    end

  // no transmit valid in sync mode
  a_tx_dv: assert property (@(posedge adc_clk) mode_i.sync_en |-> !daisy_tx_dv_o)
    else begin
      fail_cnt++;
      $error("daisy_tx_dv_o high while sync_en is set");
    end

  a_pin_dir: assert property (@(posedge adc_clk) mode_i.trig_pin_en |-> exp_n_o.dir[0])
    else begin
      fail_cnt++;
      $error("expansion pin 0 not an output while trig_pin_en is set");
    end

endmodule

bind rp_analog_top rp_analog_asserts u_asserts (
  .adc_clk       (adc_clk),
  .rst_i         (rst_i),
  .mode_i        (mode_i),
  .dac_reset_o   (dac_reset_o),
  .daisy_tx_dv_o (daisy_tx_dv_o),
  .exp_n_o       (exp_n_o)
);

// ==== source/rp_analog_top.sv ====
//////////////////////////////////////////////////////////////////////
// analog datapath top level, all logic on adc_clk
// generator, controller and trigger sources come in on ports
// ADC words must already be deserialized
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

module rp_analog_top import rp_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  raw_pair_t              adc_i,
  input  smp_pair_t              gen_i,
  input  smp_pair_t              pid_i,
  input  logic                   loop_i,
  input  logic                   trig_i,
  input  logic                   trig_scope_i,
  input  logic                   trig_gen_i,
  input  daisy_mode_t            mode_i,
  input  logic [`RP_DAISY_W-1:0] daisy_rx_i,
  input  logic                   daisy_rdy_i,
  input  exp_bank_t              exp_n_i,
  output acq_pair_t              acq_o,
  output dac_pair_t              dac_o,
  output logic                   dac_reset_o,
  output logic                   trig_ext_o,
  output logic [`RP_DAISY_W-1:0] daisy_tx_o,
  output logic                   daisy_tx_dv_o,
  output exp_bank_t              exp_n_o
);

  dac_pair_t dac_code;  // unregistered codes for loopback

  adc_front u_adc_front (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .adc_i      (adc_i),
    .dac_code_i (dac_code),
    .loop_i     (loop_i),
    .acq_o      (acq_o)
  );

  dac_mix u_dac_mix (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .gen_i       (gen_i),
    .pid_i       (pid_i),
    .dac_code_o  (dac_code),
    .dac_o       (dac_o),
    .dac_reset_o (dac_reset_o)
  );

  trig_route u_trig_route (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .trig_i        (trig_i),
    .trig_scope_i  (trig_scope_i),
    .trig_gen_i    (trig_gen_i),
    .mode_i        (mode_i),
    .daisy_rx_i    (daisy_rx_i),
    .daisy_rdy_i   (daisy_rdy_i),
    .exp_n_i       (exp_n_i),
    .trig_ext_o    (trig_ext_o),
    .daisy_tx_o    (daisy_tx_o),
    .daisy_tx_dv_o (daisy_tx_dv_o),
    .exp_n_o       (exp_n_o)
  );

endmodule

// ==== source/trig_route.sv ====
//////////////////////////////////////////////////////////////////////
// daisy trigger handling and expansion pin overlay
// any set bit in the received daisy word counts as a trigger,
// seen one cycle later
// in sync mode the external trigger is blocked while a daisy
// trigger is present and the transmit valid flag stays low
// expansion N pin 0 carries the selected trigger when enabled
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

module trig_route import rp_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  logic                   trig_i,         // external trigger pin
  input  logic                   trig_scope_i,   // scope trigger out
  input  logic                   trig_gen_i,     // generator trigger out
  input  daisy_mode_t            mode_i,
  input  logic [`RP_DAISY_W-1:0] daisy_rx_i,     // received daisy word
  input  logic                   daisy_rdy_i,    // link ready for data
  input  exp_bank_t              exp_n_i,        // bank from the register block
  output logic                   trig_ext_o,
  output logic [`RP_DAISY_W-1:0] daisy_tx_o,
  output logic                   daisy_tx_dv_o,
  output exp_bank_t              exp_n_o         // bank to the pads
);

  logic daisy_trig;  // registered OR of the rx word
  logic trig_sel;    // trigger chosen for output
  logic pin_trig;    // trigger bit for pin 0

  //////////////////////////////////////////////////////////////////////
  // trigger in
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      daisy_trig <= 1'b0;
    end else begin
      daisy_trig <= |daisy_rx_i;
    end
  end

  assign trig_ext_o = trig_i & ~(mode_i.sync_en & daisy_trig);

  //////////////////////////////////////////////////////////////////////
  // trigger out
  //////////////////////////////////////////////////////////////////////

  assign trig_sel = mode_i.trig_from_gen ? trig_gen_i : trig_scope_i;

  // whole word carries the trigger in sync mode
  assign daisy_tx_o    = mode_i.sync_en ? {`RP_DAISY_W{trig_sel}} : `RP_DAISY_IDLE;
  assign daisy_tx_dv_o = mode_i.sync_en ? 1'b0 : daisy_rdy_i;

  // pin 0 overlay, other pins untouched
  assign pin_trig = mode_i.trig_pin_en & trig_sel;

  assign exp_n_o.dat = exp_n_i.dat | {{(`RP_EXP_W-1){1'b0}}, pin_trig};
  assign exp_n_o.dir = exp_n_i.dir | {{(`RP_EXP_W-1){1'b0}}, mode_i.trig_pin_en};  // force out

endmodule

// ==== source/dac_mix.sv ====
//////////////////////////////////////////////////////////////////////
// DAC output path
// generator and controller samples are added per channel and clamped
// to the 14 bit signed range, then inverted for the DAC
// dac_code_o is combinational and feeds the loopback
// dac_o lags the inputs by two cycles with channels crossed
// dac_reset_o follows rst_i one cycle later
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

module dac_mix import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_i,
  input  smp_pair_t gen_i,        // generator samples
  input  smp_pair_t pid_i,        // controller samples
  output dac_pair_t dac_code_o,   // unregistered codes
  output dac_pair_t dac_o,        // to the DAC pins
  output logic      dac_reset_o
);

  // one extra bit so the sum never wraps
  logic signed [`RP_ADC_DW:0] sum_a;
  logic signed [`RP_ADC_DW:0] sum_b;

  dac_pair_t code_q;  // first output register

  // clamp and invert one channel
  // the two top sum bits differ only on overflow
  function automatic logic [`RP_ADC_DW-1:0] sat_inv(
    input logic signed [`RP_ADC_DW:0] sum
  );
    logic [`RP_ADC_DW-1:0] clamp;
    if (sum[`RP_ADC_DW] ^ sum[`RP_ADC_DW-1]) begin
      // sign bit then all its inverse, so 8191 or -8192
      clamp = {sum[`RP_ADC_DW], {(`RP_ADC_DW-1){~sum[`RP_ADC_DW]}}};
    end else begin
      clamp = sum[`RP_ADC_DW-1:0];
    end
    return ~clamp;  // DAC expects inverted two's complement
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////

  assign sum_a = $signed(gen_i.ch_a) + $signed(pid_i.ch_a);  // sign extended to 15 bits
  assign sum_b = $signed(gen_i.ch_b) + $signed(pid_i.ch_b);

  assign dac_code_o.ch_a = sat_inv(sum_a);
  assign dac_code_o.ch_b = sat_inv(sum_b);

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      code_q <= '0;
      dac_o  <= '0;
    end else begin
      code_q     <= dac_code_o;
      dac_o.ch_a <= code_q.ch_b;  // ch b -> dac a
      dac_o.ch_b <= code_q.ch_a;  // ch a -> dac b
    end
  end

  // DAC reset pin, registered copy of the system reset
  always_ff @(posedge adc_clk) begin
    dac_reset_o <= rst_i;
  end

endmodule

// ==== source/adc_front.sv ====
//////////////////////////////////////////////////////////////////////
// acquisition input register
// ADC words arrive already deserialized, one pair per adc_clk
// channels are crossed as on the board wiring
// loopback takes the unregistered DAC codes, not the swapped ones
// one cycle of latency, output clears on reset
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

module adc_front import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_i,
  input  raw_pair_t adc_i,       // raw ADC codes
  input  dac_pair_t dac_code_i,  // DAC codes before the output registers
  input  logic      loop_i,      // digital loopback
  output acq_pair_t acq_o
);

  raw_adc_t src_a;  // feeds acquisition channel a
  raw_adc_t src_b;  // feeds acquisition channel b

  //////////////////////////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (loop_i) begin
      src_a = dac_code_i.ch_a;  // straight through in loopback
      src_b = dac_code_i.ch_b;
    end else begin
      src_a = adc_i.ch_b;       // adc b -> ch a
      src_b = adc_i.ch_a;       // adc a -> ch b
    end
  end

  //////////////////////////////////////////////////////////////////////
  // truncating register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      acq_o <= '0;
    end else begin
      acq_o.ch_a <= src_a[`RP_ADC_DW-1 -: `RP_ADC_KEEP];  // drop the low bits
      acq_o.ch_b <= src_b[`RP_ADC_DW-1 -: `RP_ADC_KEEP];
    end
  end

endmodule

// ==== source/rp_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// sample types and packed pairs for the analog datapath
// channel a sits in the low half of every pair
// mode flag order keeps sync_en on bit 0, pin enable on bit 1
// and generator select on bit 2
//////////////////////////////////////////////////////////////////////

`include "rp_config.svh"

package rp_pkg;

  typedef logic signed [`RP_ADC_DW-1:0]   sample_t;   // generator / controller sample
  typedef logic        [`RP_ADC_DW-1:0]   raw_adc_t;  // deserialized ADC code
  typedef logic        [`RP_ADC_KEEP-1:0] acq_t;      // truncated acquisition word

  typedef struct packed {
    raw_adc_t ch_b;
    raw_adc_t ch_a;
  } raw_pair_t;

  typedef struct packed {
    acq_t ch_b;
    acq_t ch_a;
  } acq_pair_t;

  typedef struct packed {
    sample_t ch_b;
    sample_t ch_a;
  } smp_pair_t;

  // inverted DAC codes
  typedef struct packed {
    logic [`RP_ADC_DW-1:0] ch_b;
    logic [`RP_ADC_DW-1:0] ch_a;
  } dac_pair_t;

  typedef struct packed {
    logic trig_from_gen;  // 1 = generator trigger, 0 = scope trigger
    logic trig_pin_en;    // trigger on expansion N pin 0
    logic sync_en;        // daisy sync mode
  } daisy_mode_t;

  typedef struct packed {
    logic [`RP_EXP_W-1:0] dat;
    logic [`RP_EXP_W-1:0] dir;  // 1 = output
  } exp_bank_t;

endpackage

// ==== source/rp_config.svh ====
//////////////////////////////////////////////////////////////////////
// widths and constants shared by the analog datapath
// ADC and DAC samples have the same width
// the acquisition word keeps only the upper bits of each sample
// the daisy idle pattern must fit in the daisy word width
//////////////////////////////////////////////////////////////////////

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

// sample width for ADC codes and DAC codes
`define RP_ADC_DW      14

// acquisition word, upper bits of the ADC sample
`define RP_ADC_KEEP    12

// pins per expansion bank
`define RP_EXP_W       9

// daisy parallel word
`define RP_DAISY_W     16

// sent on the daisy link when sync mode is off
`define RP_DAISY_IDLE  16'h1234

`endif
